// File: design/axi_writer_settings.svh
`ifndef AXI_WRITER_SETTINGS_SVH
`define AXI_WRITER_SETTINGS_SVH

// --------------------------------------------------
// AXI4-Lite bus widths
// --------------------------------------------------

// Address width, one word
`define AXI_ADDR_W 32
// Data width, one word
`define AXI_DATA_W 32
// One strobe bit per data byte
`define AXI_STRB_W (`AXI_DATA_W / 8)

// --------------------------------------------------
// Fixed slave mapping and attributes
// --------------------------------------------------

// Added to every user address before it goes out on AW
`define SLAVE_BASE_ADDR 32'h4000_0000
// Unprivileged, secure, data access
`define AXI_AWPROT_VAL 3'b000

`endif

// File: design/axi_writer_pkg.sv
`default_nettype none

package axi_writer_pkg;

    // --------------------------------------------------
    // Execution state of the write master
    // --------------------------------------------------

    // Kept 5 bits wide so the encoding matches older monitors
    typedef enum logic [4:0] {
        IDLE       = 5'b00000,
        WRITE_DATA = 5'b00001
    } wr_state_e;

    // --------------------------------------------------
    // Write response codes on BRESP
    // --------------------------------------------------

    // Bit 1 set means the write failed
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

endpackage

`default_nettype wire

// File: design/write_cmd_if.sv
`timescale 1ns/100ps
`default_nettype none
`include "axi_writer_settings.svh"

// Carries one write command from the register block to the channel controller,
// and the completion back
interface write_cmd_if;

    import axi_writer_pkg::*;

    // Request strobe, only while no command is outstanding
    logic                   cmd_start;
    // Full AXI address, base already added
    logic [`AXI_ADDR_W-1:0] cmd_addr;
    // Write data word
    logic [`AXI_DATA_W-1:0] cmd_data;
    // One pulse per command, after the B handshake
    logic                   cmd_done;
    // Captured BRESP, valid with cmd_done
    axi_resp_e              cmd_resp;

    // Command side
    modport regs (
        output cmd_start, cmd_addr, cmd_data,
        input  cmd_done, cmd_resp
    );

    // Bus side
    modport ctrl (
        input  cmd_start, cmd_addr, cmd_data,
        output cmd_done, cmd_resp
    );

endinterface

`default_nettype wire

// File: design/write_command_regs.sv
`timescale 1ns/100ps
`default_nettype none
`include "axi_writer_settings.svh"

module write_command_regs (
    input  wire                    M_AXI_ACLK,
    input  wire                    M_AXI_ARESETN,

    // User side
    input  wire                    start_write,
    input  wire [`AXI_ADDR_W-1:0]  write_address,
    input  wire [`AXI_DATA_W-1:0]  write_data,
    output logic                   ready_to_write,
    output logic                   write_error,

    // Command to the channel controller
    write_cmd_if.regs              cmd
);

    import axi_writer_pkg::*;

    // --------------------------------------------------
    // Local signals
    // --------------------------------------------------

    // Start is honoured only while ready
    logic                   accept;
    // A command has been handed over and not yet completed
    logic                   cmd_pending;
    // Latched command payload
    logic [`AXI_ADDR_W-1:0] addr_q;
    logic [`AXI_DATA_W-1:0] data_q;
    // Completion carries an error code
    logic                   resp_err;

    assign accept = ready_to_write && start_write;

    // SLVERR and DECERR both have BRESP[1] set
    assign resp_err = (cmd.cmd_resp == SLVERR) || (cmd.cmd_resp == DECERR);

    // --------------------------------------------------
    // Handshake and sticky error
    // --------------------------------------------------

    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
        begin
            ready_to_write <= 1'b0;
            cmd_pending    <= 1'b0;
            write_error    <= 1'b0;
        end
        else if (accept)
        begin
            // Busy until the controller reports done
            ready_to_write <= 1'b0;
            cmd_pending    <= 1'b1;
            // A new write starts with a clean flag
            write_error    <= 1'b0;
        end
        else if (cmd.cmd_done)
        begin
            ready_to_write <= 1'b1;
            cmd_pending    <= 1'b0;
            write_error    <= resp_err;
        end
        else if (!cmd_pending && !ready_to_write)
        begin
            // First edge out of reset
            ready_to_write <= 1'b1;
        end
    end

    // --------------------------------------------------
    // Command payload
    // --------------------------------------------------

    // Held from the accept edge until the next accepted write
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (accept)
        begin
            addr_q <= `SLAVE_BASE_ADDR + write_address;
            data_q <= write_data;
        end
    end

    // Strobe is seen by the controller on the accept edge
    assign cmd.cmd_start = accept;
    assign cmd.cmd_addr  = addr_q;
    assign cmd.cmd_data  = data_q;

endmodule

`default_nettype wire

// File: design/write_channel_ctrl.sv
`timescale 1ns/100ps
`default_nettype none
`include "axi_writer_settings.svh"

module write_channel_ctrl (
    input  wire                          M_AXI_ACLK,
    input  wire                          M_AXI_ARESETN,

    // State for debug and status
    output axi_writer_pkg::wr_state_e    mst_exec_state,

    // Write address channel
    output logic [`AXI_ADDR_W-1:0]       M_AXI_AWADDR,
    output logic                         M_AXI_AWVALID,
    input  wire                          M_AXI_AWREADY,

    // Write data channel
    output logic [`AXI_DATA_W-1:0]       M_AXI_WDATA,
    output logic                         M_AXI_WVALID,
    input  wire                          M_AXI_WREADY,

    // Write response channel
    input  wire  [1:0]                   M_AXI_BRESP,
    input  wire                          M_AXI_BVALID,
    output logic                         M_AXI_BREADY,

    // Command from the register block
    write_cmd_if.ctrl                    cmd
);

    import axi_writer_pkg::*;

    // --------------------------------------------------
    // Local signals
    // --------------------------------------------------

    wr_state_e state;
    // One cycle after the state change, launches AW and W together
    logic      issue;
    // Completion pulse and captured response
    logic      done_q;
    axi_resp_e resp_q;
    // Response accepted this cycle
    logic      b_hs;

    assign b_hs = M_AXI_BREADY && M_AXI_BVALID;

    // --------------------------------------------------
    // Execution state
    // --------------------------------------------------

    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
        begin
            state  <= IDLE;
            issue  <= 1'b0;
            done_q <= 1'b0;
        end
        else
        begin
            // Both are single-cycle pulses
            issue  <= 1'b0;
            done_q <= 1'b0;
            case (state)
                IDLE:
                begin
                    if (cmd.cmd_start)
                    begin
                        state <= WRITE_DATA;
                        issue <= 1'b1;
                    end
                end
                WRITE_DATA:
                begin
                    // Write is over once the response is taken
                    if (b_hs)
                    begin
                        state  <= IDLE;
                        done_q <= 1'b1;
                    end
                end
                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // --------------------------------------------------
    // AW and W valids
    // --------------------------------------------------

    // Raised together, each dropped on its own handshake
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
        begin
            M_AXI_AWVALID <= 1'b0;
        end
        else if (issue)
        begin
            M_AXI_AWVALID <= 1'b1;
        end
        else if (M_AXI_AWVALID && M_AXI_AWREADY)
        begin
            M_AXI_AWVALID <= 1'b0;
        end
    end

    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
        begin
            M_AXI_WVALID <= 1'b0;
        end
        else if (issue)
        begin
            M_AXI_WVALID <= 1'b1;
        end
        else if (M_AXI_WVALID && M_AXI_WREADY)
        begin
            M_AXI_WVALID <= 1'b0;
        end
    end

    // Payload stays put while the valids wait for ready
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (issue)
        begin
            M_AXI_AWADDR <= cmd.cmd_addr;
            M_AXI_WDATA  <= cmd.cmd_data;
        end
    end

    // --------------------------------------------------
    // Write response
    // --------------------------------------------------

    // BREADY answers BVALID for exactly one cycle
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
        begin
            M_AXI_BREADY <= 1'b0;
        end
        else if (M_AXI_BREADY)
        begin
            M_AXI_BREADY <= 1'b0;
        end
        else if (M_AXI_BVALID && (state == WRITE_DATA))
        begin
            M_AXI_BREADY <= 1'b1;
        end
    end

    always_ff @(posedge M_AXI_ACLK)
    begin
        if (b_hs)
        begin
            resp_q <= axi_resp_e'(M_AXI_BRESP);
        end
    end

    assign cmd.cmd_done   = done_q;
    assign cmd.cmd_resp   = resp_q;
    assign mst_exec_state = state;

endmodule

`default_nettype wire

// File: design/axi_data_writer.sv
`timescale 1ns/100ps
`default_nettype none
`include "axi_writer_settings.svh"

module axi_data_writer (
    input  wire                          M_AXI_ACLK,
    input  wire                          M_AXI_ARESETN,

    // User write port
    input  wire                          start_write,
    input  wire  [`AXI_ADDR_W-1:0]       write_address,
    input  wire  [`AXI_DATA_W-1:0]       write_data,
    output wire                          ready_to_write,
    output wire                          write_error,
    output axi_writer_pkg::wr_state_e    mst_exec_state,

    // Write address channel
    output wire  [`AXI_ADDR_W-1:0]       M_AXI_AWADDR,
    output wire  [2:0]                   M_AXI_AWPROT,
    output wire                          M_AXI_AWVALID,
    input  wire                          M_AXI_AWREADY,

    // Write data channel
    output wire  [`AXI_DATA_W-1:0]       M_AXI_WDATA,
    output wire  [`AXI_STRB_W-1:0]       M_AXI_WSTRB,
    output wire                          M_AXI_WVALID,
    input  wire                          M_AXI_WREADY,

    // Write response channel
    input  wire  [1:0]                   M_AXI_BRESP,
    input  wire                          M_AXI_BVALID,
    output wire                          M_AXI_BREADY
);

    // --------------------------------------------------
    // Fixed write attributes
    // --------------------------------------------------

    // Full-word writes only
    assign M_AXI_WSTRB  = {`AXI_STRB_W{1'b1}};
    assign M_AXI_AWPROT = `AXI_AWPROT_VAL;

    // --------------------------------------------------
    // Command path between the two blocks
    // --------------------------------------------------

    write_cmd_if cmd_bus ();

    // User handshake, base address and sticky error
    write_command_regs u_cmd_regs (
        .M_AXI_ACLK     (M_AXI_ACLK),
        .M_AXI_ARESETN  (M_AXI_ARESETN),
        .start_write    (start_write),
        .write_address  (write_address),
        .write_data     (write_data),
        .ready_to_write (ready_to_write),
        .write_error    (write_error),
        .cmd            (cmd_bus.regs)
    );

    // AW, W and B handshakes
    write_channel_ctrl u_chan_ctrl (
        .M_AXI_ACLK     (M_AXI_ACLK),
        .M_AXI_ARESETN  (M_AXI_ARESETN),
        .mst_exec_state (mst_exec_state),
        .M_AXI_AWADDR   (M_AXI_AWADDR),
        .M_AXI_AWVALID  (M_AXI_AWVALID),
        .M_AXI_AWREADY  (M_AXI_AWREADY),
        .M_AXI_WDATA    (M_AXI_WDATA),
        .M_AXI_WVALID   (M_AXI_WVALID),
        .M_AXI_WREADY   (M_AXI_WREADY),
        .M_AXI_BRESP    (M_AXI_BRESP),
        .M_AXI_BVALID   (M_AXI_BVALID),
        .M_AXI_BREADY   (M_AXI_BREADY),
        .cmd            (cmd_bus.ctrl)
    );

endmodule

`default_nettype wire

// File: sim/axi_data_writer_asserts.sv
`timescale 1ns/100ps
`default_nettype none
`include "axi_writer_settings.svh"

module axi_data_writer_asserts (
    input  wire                    M_AXI_ACLK,
    input  wire                    M_AXI_ARESETN,
    input  wire [`AXI_ADDR_W-1:0]  M_AXI_AWADDR,
    input  wire                    M_AXI_AWVALID,
    input  wire                    M_AXI_AWREADY,
    input  wire [`AXI_DATA_W-1:0]  M_AXI_WDATA,
    input  wire                    M_AXI_WVALID,
    input  wire                    M_AXI_WREADY,
    input  wire                    M_AXI_BREADY
);

    // Count of failing properties, read back by the testbench
    int unsigned failed_checks = 0;

    // --------------------------------------------------
    // AXI4-Lite write channel rules
    // --------------------------------------------------

    // Address held until accepted
    aw_hold: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        (M_AXI_AWVALID && !M_AXI_AWREADY) |=> (M_AXI_AWVALID && $stable(M_AXI_AWADDR)))
    else
    begin
        $error("AWVALID or AWADDR changed before AWREADY");
        failed_checks++;
    end

    // Data held until accepted
    w_hold: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        (M_AXI_WVALID && !M_AXI_WREADY) |=> (M_AXI_WVALID && $stable(M_AXI_WDATA)))
    else
    begin
        $error("WVALID or WDATA changed before WREADY");
        failed_checks++;
    end

    // Response accepted with a single-cycle pulse
    b_pulse: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        M_AXI_BREADY |=> !M_AXI_BREADY)
    else
    begin
        $error("BREADY high two cycles in a row");
        failed_checks++;
    end

endmodule

bind axi_data_writer axi_data_writer_asserts u_asserts (
    .M_AXI_ACLK    (M_AXI_ACLK),
    .M_AXI_ARESETN (M_AXI_ARESETN),
    .M_AXI_AWADDR  (M_AXI_AWADDR),
    .M_AXI_AWVALID (M_AXI_AWVALID),
    .M_AXI_AWREADY (M_AXI_AWREADY),
    .M_AXI_WDATA   (M_AXI_WDATA),
    .M_AXI_WVALID  (M_AXI_WVALID),
    .M_AXI_WREADY  (M_AXI_WREADY),
    .M_AXI_BREADY  (M_AXI_BREADY)
);

`default_nettype wire

// File: sim/tb_axi_data_writer.sv
`timescale 1ns/100ps
`default_nettype none
`include "axi_writer_settings.svh"

module tb_axi_data_writer;

    import axi_writer_pkg::*;

    // Longest wait on any DUT or slave event, in cycles
    localparam int wait_limit = 100;
    localparam logic [`AXI_STRB_W-1:0] full_strb = '1;

    // --------------------------------------------------
    // DUT signals
    // --------------------------------------------------

    logic                   M_AXI_ACLK;
    logic                   M_AXI_ARESETN;
    logic                   start_write;
    logic [`AXI_ADDR_W-1:0] write_address;
    logic [`AXI_DATA_W-1:0] write_data;
    wire                    ready_to_write;
    wire                    write_error;
    wr_state_e              mst_exec_state;
    wire  [`AXI_ADDR_W-1:0] M_AXI_AWADDR;
    wire  [2:0]             M_AXI_AWPROT;
    wire                    M_AXI_AWVALID;
    logic                   M_AXI_AWREADY;
    wire  [`AXI_DATA_W-1:0] M_AXI_WDATA;
    wire  [`AXI_STRB_W-1:0] M_AXI_WSTRB;
    wire                    M_AXI_WVALID;
    logic                   M_AXI_WREADY;
    logic [1:0]             M_AXI_BRESP;
    logic                   M_AXI_BVALID;
    wire                    M_AXI_BREADY;

    // Handshake counters and payload seen on the bus
    int                     aw_count = 0;
    int                     w_count = 0;
    int                     b_count = 0;
    logic [`AXI_ADDR_W-1:0] aw_addr_seen;
    logic [2:0]             aw_prot_seen;
    logic [`AXI_DATA_W-1:0] w_data_seen;
    logic [`AXI_STRB_W-1:0] w_strb_seen;
    logic                   bvalid_prev = 1'b0;
    logic                   bready_prev = 1'b0;
    logic [31:0]            rng_state = 32'h83e9;

    axi_data_writer uut (
        .M_AXI_ACLK     (M_AXI_ACLK),
        .M_AXI_ARESETN  (M_AXI_ARESETN),
        .start_write    (start_write),
        .write_address  (write_address),
        .write_data     (write_data),
        .ready_to_write (ready_to_write),
        .write_error    (write_error),
        .mst_exec_state (mst_exec_state),
        .M_AXI_AWADDR   (M_AXI_AWADDR),
        .M_AXI_AWPROT   (M_AXI_AWPROT),
        .M_AXI_AWVALID  (M_AXI_AWVALID),
        .M_AXI_AWREADY  (M_AXI_AWREADY),
        .M_AXI_WDATA    (M_AXI_WDATA),
        .M_AXI_WSTRB    (M_AXI_WSTRB),
        .M_AXI_WVALID   (M_AXI_WVALID),
        .M_AXI_WREADY   (M_AXI_WREADY),
        .M_AXI_BRESP    (M_AXI_BRESP),
        .M_AXI_BVALID   (M_AXI_BVALID),
        .M_AXI_BREADY   (M_AXI_BREADY)
    );

    // 4 ns period
    initial
    begin
        M_AXI_ACLK = 1'b0;
        forever #2 M_AXI_ACLK = ~M_AXI_ACLK;
    end

    // --------------------------------------------------
    // Checks and helpers
    // --------------------------------------------------

    task automatic abort_run();
        $display("** FAIL **");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("[ERROR] %0t ns %s: expected %h, got %h", $time, name, exp, got);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        assert (got === exp)
        else
        begin
            $display("[ERROR] %0t ns %s: expected %b, got %b", $time, name, exp, got);
            abort_run();
        end
    endtask

    task automatic check_state(input wr_state_e exp);
        assert (mst_exec_state == exp)
        else
        begin
            $display("[ERROR] %0t ns mst_exec_state: expected %s, got %s",
                     $time, exp.name(), mst_exec_state.name());
            abort_run();
        end
    endtask

    // xorshift32 step
    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Slave delay of 0 to 6 cycles
    function automatic int next_delay();
        return int'(next_random() % 32'd7);
    endfunction

    // --------------------------------------------------
    // Bus monitor, sampled on the rising edge
    // --------------------------------------------------

    always @(posedge M_AXI_ACLK)
    begin
        if (M_AXI_ARESETN)
        begin
            if (M_AXI_AWVALID && M_AXI_AWREADY)
            begin
                aw_count++;
                aw_addr_seen = M_AXI_AWADDR;
                aw_prot_seen = M_AXI_AWPROT;
            end
            if (M_AXI_WVALID && M_AXI_WREADY)
            begin
                w_count++;
                w_data_seen = M_AXI_WDATA;
                w_strb_seen = M_AXI_WSTRB;
            end
            if (M_AXI_BVALID && M_AXI_BREADY)
                b_count++;
            // One-cycle BREADY pulse right after BVALID
            if (M_AXI_BREADY)
            begin
                assert (bvalid_prev && !bready_prev)
                else
                begin
                    $display("BREADY rose without BVALID or stayed high two cycles");
                    abort_run();
                end
            end
        end
        bvalid_prev = M_AXI_BVALID;
        bready_prev = M_AXI_BREADY;
    end

    // Protocol rules from the bound checker
    always @(uut.u_asserts.failed_checks)
    begin
        if (uut.u_asserts.failed_checks != 0)
        begin
            $display("A bound protocol assertion failed");
            abort_run();
        end
    end

    // --------------------------------------------------
    // Handshake tasks, all on the falling edge
    // --------------------------------------------------

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        while (!ready_to_write)
        begin
            @(negedge M_AXI_ACLK);
            cycles++;
            if (cycles > wait_limit)
            begin
                $display("Timeout: ready_to_write did not return high");
                abort_run();
            end
        end
    endtask

    // Slave model, READY after a delay per channel, then one response
    task automatic serve_slave(input int aw_dly, input int w_dly, input int b_dly,
                               input logic [1:0] resp);
        int   aw_wait;
        int   w_wait;
        int   cycles;
        logic aw_done;
        logic w_done;
        aw_wait = 0;
        w_wait  = 0;
        cycles  = 0;
        aw_done = 1'b0;
        w_done  = 1'b0;
        while (!(aw_done && w_done))
        begin
            @(negedge M_AXI_ACLK);
            cycles++;
            if (cycles > wait_limit)
            begin
                $display("Timeout: AW and W handshakes did not complete");
                abort_run();
            end
            // Ready raised last cycle means the handshake just happened
            if (M_AXI_AWREADY)
            begin
                M_AXI_AWREADY = 1'b0;
                aw_done       = 1'b1;
            end
            else if (!aw_done && M_AXI_AWVALID)
            begin
                if (aw_wait >= aw_dly)
                    M_AXI_AWREADY = 1'b1;
                else
                    aw_wait++;
            end
            if (M_AXI_WREADY)
            begin
                M_AXI_WREADY = 1'b0;
                w_done       = 1'b1;
            end
            else if (!w_done && M_AXI_WVALID)
            begin
                if (w_wait >= w_dly)
                    M_AXI_WREADY = 1'b1;
                else
                    w_wait++;
            end
        end
        repeat (b_dly) @(negedge M_AXI_ACLK);
        M_AXI_BVALID = 1'b1;
        M_AXI_BRESP  = resp;
        cycles       = 0;
        while (!M_AXI_BREADY)
        begin
            @(negedge M_AXI_ACLK);
            cycles++;
            if (cycles > wait_limit)
            begin
                $display("Timeout: BREADY never answered BVALID");
                abort_run();
            end
        end
        // B handshake on the next rising edge
        @(negedge M_AXI_ACLK);
        M_AXI_BVALID = 1'b0;
        M_AXI_BRESP  = 2'b00;
    endtask

    // One user write, optionally with a second start while busy
    task automatic run_write(input logic [31:0] addr, input logic [31:0] data,
                             input int aw_dly, input int w_dly, input int b_dly,
                             input logic [1:0] resp, input logic poke_busy);
        int aw_before;
        int w_before;
        int b_before;
        aw_before = aw_count;
        w_before  = w_count;
        b_before  = b_count;
        wait_ready();
        start_write   = 1'b1;
        write_address = addr;
        write_data    = data;
        @(negedge M_AXI_ACLK);
        start_write = 1'b0;
        check_bit("ready_to_write", ready_to_write, 1'b0);
        check_state(WRITE_DATA);
        if (poke_busy)
        begin
            // Must be ignored, ready is low
            start_write   = 1'b1;
            write_address = ~addr;
            write_data    = ~data;
            @(negedge M_AXI_ACLK);
            start_write = 1'b0;
        end
        serve_slave(aw_dly, w_dly, b_dly, resp);
        wait_ready();
        check_state(IDLE);
        check_value("aw handshakes", aw_count, aw_before + 1);
        check_value("w handshakes", w_count, w_before + 1);
        check_value("b handshakes", b_count, b_before + 1);
        check_value("M_AXI_AWADDR", aw_addr_seen, `SLAVE_BASE_ADDR + addr);
        check_value("M_AXI_WDATA", w_data_seen, data);
        check_value("M_AXI_AWPROT", 32'(aw_prot_seen), 32'd0);
        check_value("M_AXI_WSTRB", 32'(w_strb_seen), 32'(full_strb));
        // Sticky error follows BRESP bit 1
        check_bit("write_error", write_error, resp[1]);
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------

    task automatic test_reset();
        M_AXI_ARESETN = 1'b0;
        repeat (16)
        begin
            @(negedge M_AXI_ACLK);
            check_bit("ready_to_write", ready_to_write, 1'b0);
            check_bit("M_AXI_AWVALID", M_AXI_AWVALID, 1'b0);
            check_bit("M_AXI_WVALID", M_AXI_WVALID, 1'b0);
            check_bit("M_AXI_BREADY", M_AXI_BREADY, 1'b0);
            check_bit("write_error", write_error, 1'b0);
        end
        M_AXI_ARESETN = 1'b1;
        wait_ready();
    endtask

    task automatic test_back_pressure();
        logic [31:0] addr;
        logic [31:0] data;
        repeat (8)
        begin
            addr = next_random() & 32'h00ff_fffc;
            data = next_random();
            run_write(addr, data, next_delay(), next_delay(), next_delay(), OKAY, 1'b0);
        end
    endtask

    initial
    begin
        M_AXI_ARESETN = 1'b0;
        start_write   = 1'b0;
        write_address = '0;
        write_data    = '0;
        M_AXI_AWREADY = 1'b0;
        M_AXI_WREADY  = 1'b0;
        M_AXI_BRESP   = 2'b00;
        M_AXI_BVALID  = 1'b0;
        test_reset();
        // Slave ready at once
        run_write(32'h0000_0100, 32'hcafe_f00d, 0, 0, 0, OKAY, 1'b0);
        test_back_pressure();
        // Error stays set, then the next good write clears it
        run_write(32'h0000_0200, 32'h1234_5678, 1, 2, 1, SLVERR, 1'b0);
        run_write(32'h0000_0204, 32'h9abc_def0, 0, 1, 0, OKAY, 1'b0);
        // Start while busy, then a write with its own values
        run_write(32'h0000_0300, 32'h5555_aaaa, 2, 3, 2, OKAY, 1'b1);
        run_write(32'h0000_0304, 32'h0f0f_f0f0, 0, 0, 0, OKAY, 1'b0);
        repeat (4) @(negedge M_AXI_ACLK);
        if (uut.u_asserts.failed_checks == 0)
        begin
            $display("** PASS **");
            $finish;
        end
        else
        begin
            $display("Bound protocol assertions failed %0d times", uut.u_asserts.failed_checks);
            abort_run();
        end
    end

endmodule

`default_nettype wire

// File: axi_data_writer.f
+incdir+design
design/axi_writer_pkg.sv
design/write_cmd_if.sv
design/write_command_regs.sv
design/write_channel_ctrl.sv
design/axi_data_writer.sv
sim/axi_data_writer_asserts.sv
sim/tb_axi_data_writer.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log for the fail line

rm -f sim.log

verilator --binary --timing --assert \
    --timescale 1ns/100ps \
    --top-module tb_axi_data_writer \
    -f axi_data_writer.f \
    -o sim_axi_data_writer \
    || { echo "Build failed"; exit 1; }

./obj_dir/sim_axi_data_writer +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

grep -q '^\*\* FAIL \*\*$' sim.log && { echo "Simulation failed"; exit 1; }
grep -q '^\*\* PASS \*\*$' sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"
